//--- all.f
ccip_types_pkg.sv
rob_cfg_pkg.sv
rob_buffer.sv
rd_order_shim.sv
host_rd_top.sv
tb_host_rd_checker.sv
tb_host_rd.sv

//--- Bender.yml
package:
  name: host_rd

sources:
  # Type packages come first because every module imports them
  - ccip_types_pkg.sv
  - rob_cfg_pkg.sv

  # Design, leaves first
  - rob_buffer.sv
  - rd_order_shim.sv
  - host_rd_top.sv

  # Testbench
  - target: test
    files:
      - tb_host_rd_checker.sv
      - tb_host_rd.sv

//--- host_rd_tests.txt
# REQ tag_hex lines addr_hex | RSP request beat | SHUF request | MMIO tid_hex addr_hex
# PROBE host_alm_full expected_alm_full | END test_number, requests count from 0 per test
# test 1 single-line reads answered in reverse order
REQ 00a1 1 0001000
REQ 00b2 1 0001040
REQ 00c3 1 0001080
REQ 00d4 1 00010c0
RSP 3 0
RSP 2 0
RSP 1 0
RSP 0 0
END 1
# test 2 four-line reads with shuffled beats
REQ 1235 4 0002000
REQ 2346 4 0002100
REQ 3457 4 0002200
SHUF 1
SHUF 2
SHUF 0
END 2
# test 3 mixed lengths with beats interleaved across requests
REQ 4001 2 0003000
REQ 4002 1 0003010
REQ 4003 3 0003020
REQ 400c 4 0003040
RSP 3 2
RSP 2 1
RSP 0 1
RSP 3 0
RSP 1 0
RSP 2 2
RSP 3 3
RSP 2 0
RSP 0 0
RSP 3 1
END 3
# test 4 MMIO requests while read beats drain
REQ 5a0f 4 0004000
REQ 5b1e 1 0004100
REQ 5c2d 4 0004200
RSP 0 0
RSP 0 1
MMIO 011 0a8
RSP 0 2
RSP 0 3
MMIO 012 0b0
RSP 1 0
SHUF 2
MMIO 013 0b8
END 4
# test 5 almost-full rises once more than 8 lines are outstanding
REQ 6001 4 0005000
REQ 6002 4 0005100
PROBE 0 0
REQ 6003 4 0005200
PROBE 0 1
SHUF 0
SHUF 2
SHUF 1
END 5
# test 6 almost-full is low once drained and follows the host flag
PROBE 0 0
PROBE 1 1
PROBE 0 0
END 6

//--- tb_host_rd.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * Testbench for the host read channel
 * Drives requests, out-of-order read beats, MMIO traffic and almost-full
 * probes from a data file, with a host model that answers by slot index
 */

module tb_host_rd
    import ccip_types_pkg::*;
    import rob_cfg_pkg::*;
();

    localparam int drain_timeout = 200;

    // What the host model remembers about each request of a test
    typedef struct packed {
        t_mdata      tag;
        t_cl_len     cl_len;
        logic [41:0] address;
        t_rob_idx    slot;
    } t_host_req;

    logic        clk;
    logic        reset_n;
    t_c0_tx_req  afu_c0_tx;
    t_c0_rx      afu_c0_rx;
    logic        afu_c0_alm_full;
    t_c0_tx_req  host_c0_tx;
    t_c0_rx      host_c0_rx;
    logic        host_c0_alm_full;
    logic        probe_en;
    logic        probe_level;

    int          error_count;
    int          reads_pending;
    int          mmio_pending;
    t_mdata      head_tag;
    t_cl_num     head_cl_num;

    t_host_req   reqs [rob_entries];
    int          req_count;
    int          seed = 49;
    logic        aborted;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;

    // File parsing state
    int                 fd;
    int                 code;
    logic [8*8-1:0]     kind;
    logic [8*120-1:0]   text;
    t_mdata             f_tag;
    logic [41:0]        f_addr;
    logic [8:0]         f_tid;
    logic [11:0]        f_maddr;
    int                 f_a;
    int                 f_b;

    host_rd_top host_rd_top_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .afu_c0_tx        (afu_c0_tx),
        .afu_c0_rx        (afu_c0_rx),
        .afu_c0_alm_full  (afu_c0_alm_full),
        .host_c0_tx       (host_c0_tx),
        .host_c0_rx       (host_c0_rx),
        .host_c0_alm_full (host_c0_alm_full)
    );

    tb_host_rd_checker tb_host_rd_checker_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .afu_c0_tx       (afu_c0_tx),
        .afu_c0_rx       (afu_c0_rx),
        .afu_c0_alm_full (afu_c0_alm_full),
        .host_c0_tx      (host_c0_tx),
        .host_c0_rx      (host_c0_rx),
        .probe_en        (probe_en),
        .probe_level     (probe_level),
        .error_count     (error_count),
        .reads_pending   (reads_pending),
        .mmio_pending    (mmio_pending),
        .head_tag        (head_tag),
        .head_cl_num     (head_cl_num)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Drivers and host model
    // ========================================

    // Every strobe lasts one cycle and is driven 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        afu_c0_tx.valid = 1'b0;
        host_c0_rx.rsp_valid = 1'b0;
        host_c0_rx.mmio_valid = 1'b0;
        probe_en = 1'b0;
    endtask

    task automatic issue_request(input t_mdata tag, input int lines, input logic [41:0] addr);
        next_cycle();
        afu_c0_tx.valid = 1'b1;
        afu_c0_tx.cl_len = t_cl_len'(lines - 1);
        afu_c0_tx.mdata = tag;
        afu_c0_tx.address = addr;
        // The host only ever learns the slot index
        @(negedge clk);
        reqs[req_count] = '{tag: tag, cl_len: t_cl_len'(lines - 1), address: addr,
                            slot: t_rob_idx'(host_c0_tx.mdata)};
        req_count++;
    endtask

    task automatic send_read_beat(input int n, input int b);
        next_cycle();
        host_c0_rx.hdr = '0;
        host_c0_rx.hdr.mem.resp_type = rsp_rdline;
        host_c0_rx.hdr.mem.mdata = t_mdata'(reqs[n].slot);
        host_c0_rx.hdr.mem.cl_num = t_cl_num'(b);
        host_c0_rx.hdr.mem.error = reqs[n].tag[0];
        host_c0_rx.hdr.mem.vc_used = reqs[n].tag[2:1];
        host_c0_rx.hdr.mem.hit_miss = reqs[n].tag[3];
        host_c0_rx.data = t_cl_data'(reqs[n].address) + t_cl_data'(b);
        host_c0_rx.rsp_valid = 1'b1;
    endtask

    // Fisher-Yates over the beats of one request
    task automatic send_shuffled_beats(input int n);
        int order [max_beats];
        int i;
        int j;
        int tmp;
        for (i = 0; i < max_beats; i++)
            order[i] = i;
        for (i = int'(reqs[n].cl_len); i > 0; i--)
        begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i <= int'(reqs[n].cl_len); i++)
            send_read_beat(n, order[i]);
    endtask

    task automatic send_mmio(input logic [8:0] tid, input logic [11:0] addr);
        next_cycle();
        host_c0_rx.hdr = '0;
        host_c0_rx.hdr.mmio.resp_type = rsp_mmio_rd;
        host_c0_rx.hdr.mmio.tid = tid;
        host_c0_rx.hdr.mmio.address = addr;
        host_c0_rx.hdr.mmio.length = 2'd1;
        host_c0_rx.data = t_cl_data'({tid, addr}) ^ 64'h5a5a_0000_0000_0000;
        host_c0_rx.mmio_valid = 1'b1;
    endtask

    task automatic probe_alm_full(input int host_flag, input int level);
        next_cycle();
        host_c0_alm_full = (host_flag != 0);
        probe_en = 1'b1;
        probe_level = (level != 0);
    endtask

    // ========================================
    // Test sequencing
    // ========================================

    task automatic finish_test(input int num);
        int cycles;
        cycles = 0;
        next_cycle();
        while ((reads_pending != 0 || mmio_pending != 0) && cycles < drain_timeout)
        begin
            next_cycle();
            cycles++;
        end
        tests_run++;
        if (reads_pending != 0 || mmio_pending != 0)
        begin
            if (reads_pending != 0)
                $display("ERROR: test %0d timed out waiting for read beat tag 0x%h cl_num %0d",
                         num, head_tag, head_cl_num);
            else
                $display("ERROR: test %0d timed out waiting for an MMIO request", num);
            aborted = 1'b1;
            tests_failed++;
        end
        else if (error_count != test_start_errors)
        begin
            $display("test %0d failed with %0d errors", num, error_count - test_start_errors);
            tests_failed++;
        end
        else
        begin
            $display("test %0d passed", num);
        end
        test_start_errors = error_count;
        req_count = 0;
    endtask

    task automatic reject_line(input string msg);
        $display("ERROR: bad line in host_rd_tests.txt, %s", msg);
        aborted = 1'b1;
    endtask

    task automatic run_line();
        if (kind == "#")
        begin
            code = $fgets(text, fd);
        end
        else if (kind == "REQ")
        begin
            code = $fscanf(fd, "%h %d %h", f_tag, f_a, f_addr);
            if (code != 3 || f_a < 1 || f_a > max_beats || req_count >= rob_entries)
                reject_line("REQ needs a tag, 1 to 4 lines and an address");
            else
                issue_request(f_tag, f_a, f_addr);
        end
        else if (kind == "RSP")
        begin
            code = $fscanf(fd, "%d %d", f_a, f_b);
            if (code != 2 || f_a >= req_count || f_b > int'(reqs[f_a].cl_len))
                reject_line("RSP names a request or beat that does not exist");
            else
                send_read_beat(f_a, f_b);
        end
        else if (kind == "SHUF")
        begin
            code = $fscanf(fd, "%d", f_a);
            if (code != 1 || f_a >= req_count)
                reject_line("SHUF names a request that does not exist");
            else
                send_shuffled_beats(f_a);
        end
        else if (kind == "MMIO")
        begin
            code = $fscanf(fd, "%h %h", f_tid, f_maddr);
            if (code != 2)
                reject_line("MMIO needs a tid and an address");
            else
                send_mmio(f_tid, f_maddr);
        end
        else if (kind == "PROBE")
        begin
            code = $fscanf(fd, "%d %d", f_a, f_b);
            if (code != 2)
                reject_line("PROBE needs a host flag and an expected level");
            else
                probe_alm_full(f_a, f_b);
        end
        else if (kind == "END")
        begin
            code = $fscanf(fd, "%d", f_a);
            if (code != 1)
                reject_line("END needs a test number");
            else
                finish_test(f_a);
        end
        else
        begin
            reject_line("unknown line kind");
        end
    endtask

    initial
    begin
        reset_n = 1'b0;
        afu_c0_tx = '0;
        host_c0_rx = '0;
        host_c0_alm_full = 1'b0;
        probe_en = 1'b0;
        probe_level = 1'b0;
        req_count = 0;
        aborted = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        test_start_errors = 0;

        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        fd = $fopen("host_rd_tests.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open host_rd_tests.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, "%s", kind) == 1)
            run_line();
        if (fd != 0)
            $fclose(fd);

        // A few idle cycles catch any stray beat after the last test
        repeat (8) next_cycle();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (!aborted && tests_failed == 0 && error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_host_rd_checker.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * Testbench checker for the host read channel
 * Builds the expected read and MMIO streams from the traffic that enters
 * the DUT and compares every accelerator-side pulse against them
 */

module tb_host_rd_checker
    import ccip_types_pkg::*;
    import rob_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // DUT traffic being watched
    input  t_c0_tx_req afu_c0_tx,
    input  t_c0_rx     afu_c0_rx,
    input  logic       afu_c0_alm_full,
    input  t_c0_tx_req host_c0_tx,
    input  t_c0_rx     host_c0_rx,

    // Almost-full probe from the stimulus
    input  logic       probe_en,
    input  logic       probe_level,

    output int         error_count,
    output int         reads_pending,
    output int         mmio_pending,
    output t_mdata     head_tag,
    output t_cl_num    head_cl_num
);

    // One expected read beat, in request order
    typedef struct packed {
        t_mdata      tag;
        t_cl_num     cl_num;
        t_rob_idx    slot;
        t_cl_data    data;
    } t_exp_beat;

    t_exp_beat              read_q [$];
    t_c0_rx                 mmio_q [$];
    logic [rob_entries-1:0] in_flight = '0;
    int                     err_cnt = 0;

    assign error_count = err_cnt;

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic compare_field(input string field, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
        if (exp_val !== got_val)
        begin
            $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, field, exp_val, got_val);
            err_cnt++;
        end
    endtask

    // ========================================
    // Expected streams
    // ========================================

    // Each line of a request gets its own slot, starting at the host tag
    task automatic record_request();
        t_exp_beat beat;
        int        b;
        if (host_c0_tx.mdata >= t_mdata'(rob_entries))
            report_error($sformatf("host tag 0x%0h is not a slot index", host_c0_tx.mdata));
        compare_field("host_c0_tx.cl_len", afu_c0_tx.cl_len, host_c0_tx.cl_len);
        compare_field("host_c0_tx.address", afu_c0_tx.address, host_c0_tx.address);
        for (b = 0; b <= int'(afu_c0_tx.cl_len); b++)
        begin
            beat.tag = afu_c0_tx.mdata;
            beat.cl_num = t_cl_num'(b);
            beat.slot = t_rob_idx'(host_c0_tx.mdata) + t_rob_idx'(b);
            beat.data = t_cl_data'(afu_c0_tx.address) + t_cl_data'(b);
            if (in_flight[beat.slot])
                report_error($sformatf("slot %0d handed out while still in flight", beat.slot));
            in_flight[beat.slot] = 1'b1;
            read_q.push_back(beat);
        end
    endtask

    // ========================================
    // Output comparison
    // ========================================

    task automatic check_read_beat();
        t_exp_beat      beat;
        t_c0_rx_mem_hdr hdr;
        if (read_q.size() == 0)
        begin
            report_error("read beat reached the accelerator with no request outstanding");
        end
        else
        begin
            beat = read_q.pop_front();
            hdr = afu_c0_rx.hdr.mem;
            in_flight[beat.slot] = 1'b0;
            compare_field("resp_type", rsp_rdline, hdr.resp_type);
            compare_field("mdata", beat.tag, hdr.mdata);
            compare_field("cl_num", beat.cl_num, hdr.cl_num);
            // The host model derives the status bits from the low tag bits
            compare_field("error", beat.tag[0], hdr.error);
            compare_field("vc_used", beat.tag[2:1], hdr.vc_used);
            compare_field("hit_miss", beat.tag[3], hdr.hit_miss);
            compare_field("data", beat.data, afu_c0_rx.data);
        end
    endtask

    // MMIO requests must come out exactly as the host sent them
    task automatic check_mmio();
        t_c0_rx exp_rx;
        if (mmio_q.size() == 0)
        begin
            report_error("MMIO request reached the accelerator without one from the host");
        end
        else
        begin
            exp_rx = mmio_q.pop_front();
            compare_field("mmio resp_type", exp_rx.hdr.mmio.resp_type,
                          afu_c0_rx.hdr.mmio.resp_type);
            compare_field("mmio tid", exp_rx.hdr.mmio.tid, afu_c0_rx.hdr.mmio.tid);
            compare_field("mmio address", exp_rx.hdr.mmio.address, afu_c0_rx.hdr.mmio.address);
            compare_field("mmio length", exp_rx.hdr.mmio.length, afu_c0_rx.hdr.mmio.length);
            compare_field("mmio data", exp_rx.data, afu_c0_rx.data);
        end
    endtask

    // Everything is sampled mid-cycle, away from both clock edges
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            // The request strobe reaches the host in the same cycle
            compare_field("host_c0_tx.valid", afu_c0_tx.valid, host_c0_tx.valid);
            if (afu_c0_tx.valid)
                record_request();
            if (host_c0_rx.mmio_valid)
                mmio_q.push_back(host_c0_rx);
            if (probe_en)
                compare_field("afu_c0_alm_full", probe_level, afu_c0_alm_full);
            if (afu_c0_rx.rsp_valid && afu_c0_rx.mmio_valid)
                report_error("read beat and MMIO request presented in the same cycle");
            if (afu_c0_rx.rsp_valid)
                check_read_beat();
            if (afu_c0_rx.mmio_valid)
                check_mmio();
        end
        reads_pending = read_q.size();
        mmio_pending = mmio_q.size();
        if (read_q.size() != 0)
        begin
            head_tag = read_q[0].tag;
            head_cl_num = read_q[0].cl_num;
        end
    end

endmodule

`default_nettype wire

//--- host_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * Host read channel top level
 * Flat accelerator and host ports around the read-ordering shim
 */

module host_rd_top
    import ccip_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Accelerator side
    input  t_c0_tx_req afu_c0_tx,
    output t_c0_rx     afu_c0_rx,
    output logic       afu_c0_alm_full,

    // Host side
    output t_c0_tx_req host_c0_tx,
    input  t_c0_rx     host_c0_rx,
    input  logic       host_c0_alm_full
);

    rd_order_shim rd_order_shim_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .afu_c0_tx        (afu_c0_tx),
        .afu_c0_rx        (afu_c0_rx),
        .afu_c0_alm_full  (afu_c0_alm_full),
        .host_c0_tx       (host_c0_tx),
        .host_c0_rx       (host_c0_rx),
        .host_c0_alm_full (host_c0_alm_full)
    );

endmodule

`default_nettype wire

//--- rd_order_shim.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * Read-ordering shim for the channel 0 host interface
 * Swaps request tags for buffer slot indices, returns read beats in
 * request order with the original tag, lines MMIO requests up with the
 * buffer output and raises almost-full when slots run low
 */

module rd_order_shim
    import ccip_types_pkg::*;
    import rob_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Accelerator side
    input  t_c0_tx_req afu_c0_tx,
    output t_c0_rx     afu_c0_rx,
    output logic       afu_c0_alm_full,

    // Host side
    output t_c0_tx_req host_c0_tx,
    input  t_c0_rx     host_c0_rx,
    input  logic       host_c0_alm_full
);

    logic [2:0]    n_alloc;
    t_rob_idx      alloc_idx;
    logic          rob_not_full;

    t_c0_rx        c0_rx_q;
    t_c0_rx        c0_rx_qq;
    logic          rd_beat_q;
    t_rob_idx      wr_idx;
    t_rob_payload  wr_payload;

    logic          non_rd_valid;
    logic          deq_en;
    logic          deq_en_q;
    logic          rob_data_rdy;
    logic          rob_not_empty;
    t_rob_payload  rob_payload;
    t_rob_meta     rob_meta;

    logic          rd_sop;
    logic          rd_eop;
    t_rob_meta     sop_meta;
    t_rob_meta     cur_meta;

    // ========================================
    // Request path
    // ========================================

    // Every line of a request gets its own slot
    assign n_alloc = afu_c0_tx.valid ? 3'(afu_c0_tx.cl_len) + 3'd1 : 3'd0;

    // The original tag stays in the buffer and the host only sees the slot
    always_comb
    begin
        host_c0_tx = afu_c0_tx;
        host_c0_tx.mdata = t_mdata'(alloc_idx);
    end

    // Buffer space is reserved up front, so almost-full is the only stall
    assign afu_c0_alm_full = host_c0_alm_full || !rob_not_full;

    // ========================================
    // Response registers
    // ========================================

    // First stage feeds the buffer write, second lines MMIO up with the output
    always_ff @(posedge clk)
    begin
        c0_rx_q <= host_c0_rx;
        c0_rx_qq <= c0_rx_q;
        if (!reset_n)
        begin
            c0_rx_q.rsp_valid <= 1'b0;
            c0_rx_q.mmio_valid <= 1'b0;
            c0_rx_qq.rsp_valid <= 1'b0;
            c0_rx_qq.mmio_valid <= 1'b0;
        end
    end

    assign rd_beat_q = c0_rx_q.rsp_valid && (c0_rx_q.hdr.mem.resp_type == rsp_rdline);

    // The host returns the base slot, so beats of a packet land on adjacent slots
    assign wr_idx = t_rob_idx'(c0_rx_q.hdr.mem.mdata) + t_rob_idx'(c0_rx_q.hdr.mem.cl_num);

    assign wr_payload = '{error:    c0_rx_q.hdr.mem.error,
                          vc_used:  c0_rx_q.hdr.mem.vc_used,
                          hit_miss: c0_rx_q.hdr.mem.hit_miss,
                          cl_num:   c0_rx_q.hdr.mem.cl_num,
                          data:     c0_rx_q.data};

    rob_buffer rob_buffer_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .alloc_n       (n_alloc),
        .alloc_meta    ('{cl_len: afu_c0_tx.cl_len, mdata: afu_c0_tx.mdata}),
        .alloc_idx     (alloc_idx),
        .not_full      (rob_not_full),
        .wr_en         (rd_beat_q),
        .wr_idx        (wr_idx),
        .wr_payload    (wr_payload),
        .deq_en        (deq_en),
        .not_empty     (rob_not_empty),
        .first_payload (rob_payload),
        .first_meta    (rob_meta)
    );

    // ========================================
    // Dequeue and packet tracking
    // ========================================

    // Any incoming non-read traffic claims the output slot two cycles from now
    assign non_rd_valid = host_c0_rx.mmio_valid ||
                          (host_c0_rx.rsp_valid && (host_c0_rx.hdr.mem.resp_type != rsp_rdline));
    assign deq_en = rob_not_empty && !non_rd_valid;

    // Buffer data is ready two cycles after its dequeue
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            deq_en_q <= 1'b0;
            rob_data_rdy <= 1'b0;
        end
        else
        begin
            deq_en_q <= deq_en;
            rob_data_rdy <= deq_en_q;
        end
    end

    // Only the base slot holds valid metadata, later beats reuse the latched copy
    assign cur_meta = rd_sop ? rob_meta : sop_meta;
    assign rd_eop = (rob_payload.cl_num == cur_meta.cl_len);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_sop <= 1'b1;
        end
        else if (rob_data_rdy)
        begin
            rd_sop <= rd_eop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rob_data_rdy && rd_sop)
        begin
            sop_meta <= rob_meta;
        end
    end

    // ========================================
    // Response merge
    // ========================================

    always_comb
    begin
        afu_c0_rx = c0_rx_qq;
        if (rob_data_rdy)
        begin
            // Rebuild the memory view for the ordered beat
            afu_c0_rx.hdr = '0;
            afu_c0_rx.hdr.mem.resp_type = rsp_rdline;
            afu_c0_rx.hdr.mem.mdata = cur_meta.mdata;
            afu_c0_rx.hdr.mem.cl_num = rob_payload.cl_num;
            afu_c0_rx.hdr.mem.error = rob_payload.error;
            afu_c0_rx.hdr.mem.vc_used = rob_payload.vc_used;
            afu_c0_rx.hdr.mem.hit_miss = rob_payload.hit_miss;
            afu_c0_rx.data = rob_payload.data;
            afu_c0_rx.rsp_valid = 1'b1;
        end
        else if (c0_rx_qq.rsp_valid && (c0_rx_qq.hdr.mem.resp_type == rsp_rdline))
        begin
            // Raw host read beats only reach the accelerator through the buffer
            afu_c0_rx.rsp_valid = 1'b0;
        end
    end

    // Packet start tracking must match the beat numbers the host wrote
    sop_matches_cl_num: assert property (@(posedge clk) disable iff (!reset_n)
        rob_data_rdy |-> (rd_sop == (rob_payload.cl_num == '0)))
        else $error("start of packet disagrees with cl_num %0d", rob_payload.cl_num);

endmodule

`default_nettype wire

//--- rob_buffer.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * Reorder buffer
 * Reserves slots in request order, takes beats by index in any order
 * and releases them from the head with two cycles of read latency
 */

module rob_buffer
    import rob_cfg_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,

    // Allocation, one request of alloc_n lines per cycle
    input  logic [2:0]   alloc_n,
    input  t_rob_meta    alloc_meta,
    output t_rob_idx     alloc_idx,
    output logic         not_full,

    // Out-of-order writes
    input  logic         wr_en,
    input  t_rob_idx     wr_idx,
    input  t_rob_payload wr_payload,

    // In-order release
    input  logic         deq_en,
    output logic         not_empty,
    output t_rob_payload first_payload,
    output t_rob_meta    first_meta
);

    // One extra bit so that a completely free buffer can be counted
    typedef logic [$bits(t_rob_idx):0] t_free_cnt;

    t_rob_idx                 alloc_ptr;
    t_rob_idx                 head_ptr;
    t_free_cnt                free_cnt;
    logic [rob_entries-1:0]   filled;

    t_rob_payload             data_mem [rob_entries];
    t_rob_meta                meta_mem [rob_entries];

    t_rob_payload             payload_q;
    t_rob_meta                meta_q;

    // ========================================
    // Slot bookkeeping
    // ========================================

    assign alloc_idx = alloc_ptr;
    assign not_empty = filled[head_ptr];

    // Room must remain for the requests still allowed after almost-full
    assign not_full = (free_cnt >= t_free_cnt'(min_free_slots));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            head_ptr <= '0;
            free_cnt <= t_free_cnt'(rob_entries);
            filled <= '0;
        end
        else
        begin
            // Slots are taken at allocation and given back one per dequeue
            alloc_ptr <= alloc_ptr + t_rob_idx'(alloc_n);
            free_cnt <= free_cnt - t_free_cnt'(alloc_n) + t_free_cnt'(deq_en);

            if (deq_en)
            begin
                head_ptr <= head_ptr + 1'b1;
                filled[head_ptr] <= 1'b0;
            end

            // A write never hits the head slot being released, so order is safe
            if (wr_en)
            begin
                filled[wr_idx] <= 1'b1;
            end
        end
    end

    // ========================================
    // Storage and two-stage read
    // ========================================

    always_ff @(posedge clk)
    begin
        // Metadata is only meaningful at the base slot of a request
        if (alloc_n != 3'd0)
        begin
            meta_mem[alloc_ptr] <= alloc_meta;
        end

        if (wr_en)
        begin
            data_mem[wr_idx] <= wr_payload;
        end
    end

    // First stage reads the head, second stage presents it
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            payload_q <= data_mem[head_ptr];
            meta_q <= meta_mem[head_ptr];
        end
        first_payload <= payload_q;
        first_meta <= meta_q;
    end

    // ========================================
    // Checks
    // ========================================

    // A slot must be released before the host can fill it again
    wr_to_empty_slot: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en |-> !filled[wr_idx])
        else $error("write to filled slot %0d", wr_idx);

    // The shim only releases a head that has arrived
    deq_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> not_empty)
        else $error("dequeue from empty head slot %0d", head_ptr);

endmodule

`default_nettype wire

//--- rob_cfg_pkg.sv
`default_nettype none

/*
 * Reorder buffer configuration
 * Slot count, almost-full threshold and the per-slot storage types
 */

package rob_cfg_pkg;

    import ccip_types_pkg::*;

    // One slot holds one line
    localparam int rob_entries = 16;
    localparam int max_beats = 4;
    localparam int alm_full_threshold = 2;

    // Room still needed for alm_full_threshold requests of full length
    localparam int min_free_slots = alm_full_threshold * max_beats;

    typedef logic [$clog2(rob_entries)-1:0] t_rob_idx;

    typedef struct packed {
        t_cl_len       cl_len;
        t_mdata        mdata;
    } t_rob_meta;

    typedef struct packed {
        logic          error;
        logic [1:0]    vc_used;
        logic          hit_miss;
        t_cl_num       cl_num;
        t_cl_data      data;
    } t_rob_payload;

endpackage

`default_nettype wire

//--- ccip_types_pkg.sv
`default_nettype none

/*
 * Host memory channel types for the read path
 * Line and tag widths, the read request header, the two views of the
 * channel 0 response header and the response type codes
 */

package ccip_types_pkg;

    localparam int cl_data_width = 64;
    localparam int mdata_width = 16;

    typedef logic [cl_data_width-1:0] t_cl_data;
    typedef logic [mdata_width-1:0] t_mdata;

    // Beat number inside a multi-line packet, and request length minus one
    typedef logic [1:0] t_cl_num;
    typedef logic [1:0] t_cl_len;

    typedef enum logic [3:0] {
        rsp_rdline  = 4'h0,
        rsp_mmio_rd = 4'h8,
        rsp_mmio_wr = 4'h9
    } t_resp_type;

    // Read request toward the host, one header per request of 1 to 4 lines
    typedef struct packed {
        logic          valid;
        t_cl_len       cl_len;
        t_mdata        mdata;
        logic [41:0]   address;
    } t_c0_tx_req;

    // Memory response view; resp_type must stay in the top bits of both views
    typedef struct packed {
        t_resp_type    resp_type;
        t_mdata        mdata;
        t_cl_num       cl_num;
        logic          error;
        logic [1:0]    vc_used;
        logic          hit_miss;
        logic [1:0]    rsvd;
    } t_c0_rx_mem_hdr;

    // MMIO request view of the same header word
    typedef struct packed {
        t_resp_type    resp_type;
        logic [8:0]    tid;
        logic [11:0]   address;
        logic [1:0]    length;
        logic          rsvd;
    } t_c0_rx_mmio_hdr;

    typedef union packed {
        t_c0_rx_mem_hdr  mem;
        t_c0_rx_mmio_hdr mmio;
    } t_c0_rx_hdr_u;

    typedef struct packed {
        logic          rsp_valid;
        logic          mmio_valid;
        t_c0_rx_hdr_u  hdr;
        t_cl_data      data;
    } t_c0_rx;

endpackage

`default_nettype wire
